//--- source/pipe_pkg.sv
// pipe_pkg: shared word and field types, opcode and funct values, ALU codes, data memory size
`default_nettype none

package pipe_pkg;

    // data path and instruction field types
    typedef logic [31:0] word_t;
    typedef logic [4:0]  regbits_t;
    typedef logic [5:0]  opcode_t;
    typedef logic [5:0]  funct_t;
    typedef logic [4:0]  shamt_t;
    typedef logic [3:0]  aluop_t;

    // opcodes, MIPS encoding
    localparam opcode_t OP_RTYPE = 6'h00;
    localparam opcode_t OP_ADDIU = 6'h09;
    localparam opcode_t OP_SLTI  = 6'h0a;
    localparam opcode_t OP_ANDI  = 6'h0c;
    localparam opcode_t OP_ORI   = 6'h0d;
    localparam opcode_t OP_XORI  = 6'h0e;
    localparam opcode_t OP_LUI   = 6'h0f;
    localparam opcode_t OP_LW    = 6'h23;
    localparam opcode_t OP_SW    = 6'h2b;
    // halt is all ones
    localparam opcode_t OP_HALT  = 6'h3f;

    // funct codes for r-type
    localparam funct_t FN_SLL  = 6'h00;
    localparam funct_t FN_SRL  = 6'h02;
    localparam funct_t FN_ADDU = 6'h21;
    localparam funct_t FN_SUBU = 6'h23;
    localparam funct_t FN_AND  = 6'h24;
    localparam funct_t FN_OR   = 6'h25;
    localparam funct_t FN_XOR  = 6'h26;
    localparam funct_t FN_NOR  = 6'h27;
    localparam funct_t FN_SLT  = 6'h2a;
    localparam funct_t FN_SLTU = 6'h2b;

    // alu operation codes
    localparam aluop_t ALU_ADD  = 4'd0;
    localparam aluop_t ALU_SUB  = 4'd1;
    localparam aluop_t ALU_AND  = 4'd2;
    localparam aluop_t ALU_OR   = 4'd3;
    localparam aluop_t ALU_XOR  = 4'd4;
    localparam aluop_t ALU_NOR  = 4'd5;
    localparam aluop_t ALU_SLT  = 4'd6;
    localparam aluop_t ALU_SLTU = 4'd7;
    localparam aluop_t ALU_SLL  = 4'd8;
    localparam aluop_t ALU_SRL  = 4'd9;
    localparam aluop_t ALU_LUI  = 4'd10;

    // data memory, word addressed
    localparam int DMEM_WORDS  = 64;
    localparam int DMEM_ADDR_W = 6;

endpackage

`default_nettype wire

//--- source/alu.sv
// alu: combinational 32-bit integer ALU for the supported MIPS subset
`timescale 1ns/100ps
`default_nettype none

module alu (
    input  pipe_pkg::aluop_t aluop,
    input  pipe_pkg::word_t  port_a,
    input  pipe_pkg::word_t  port_b,
    input  pipe_pkg::shamt_t shamt,
    output pipe_pkg::word_t  port_o,
    output logic             zero
);

    // compare results, one bit each
    logic lt_signed;
    logic lt_unsigned;

    assign lt_signed   = $signed(port_a) < $signed(port_b);
    assign lt_unsigned = port_a < port_b;

    always_comb begin
        case (aluop)
            pipe_pkg::ALU_ADD: begin
                port_o = port_a + port_b;
            end
            pipe_pkg::ALU_SUB: begin
                port_o = port_a - port_b;
            end
            pipe_pkg::ALU_AND: begin
                port_o = port_a & port_b;
            end
            pipe_pkg::ALU_OR: begin
                port_o = port_a | port_b;
            end
            pipe_pkg::ALU_XOR: begin
                port_o = port_a ^ port_b;
            end
            pipe_pkg::ALU_NOR: begin
                port_o = ~(port_a | port_b);
            end
            pipe_pkg::ALU_SLT: begin
                port_o = {31'd0, lt_signed};
            end
            pipe_pkg::ALU_SLTU: begin
                port_o = {31'd0, lt_unsigned};
            end
            // shifts act on the b side (rt)
            pipe_pkg::ALU_SLL: begin
                port_o = port_b << shamt;
            end
            pipe_pkg::ALU_SRL: begin
                port_o = port_b >> shamt;
            end
            // immediate goes into the upper half
            pipe_pkg::ALU_LUI: begin
                port_o = {port_b[15:0], 16'h0000};
            end
            default: begin
                port_o = '0;
            end
        endcase
    end

    // for a branch compare further up the pipe
    assign zero = (port_o == '0);

endmodule

`default_nettype wire

//--- source/decode_stage.sv
// decode_stage: splits the instruction word into fields, derives controls, latches them per strobe
`timescale 1ns/100ps
`default_nettype none

module decode_stage (
    input  logic               CLK,
    input  logic               nRST,
    input  logic               instr_strobe,
    input  logic               flush,
    input  pipe_pkg::word_t    instr,
    input  pipe_pkg::word_t    rs_data,
    input  pipe_pkg::word_t    rt_data,
    input  pipe_pkg::word_t    npc,
    output logic               dec_valid,
    output pipe_pkg::aluop_t   dec_aluop,
    output logic               dec_alusrc,
    output pipe_pkg::word_t    dec_port_a,
    output pipe_pkg::word_t    dec_port_b,
    output pipe_pkg::word_t    dec_imm_ext,
    output pipe_pkg::shamt_t   dec_shamt,
    output pipe_pkg::regbits_t dec_rw,
    output logic               dec_regwen,
    output logic               dec_memtoreg,
    output logic               dec_dren,
    output logic               dec_dwen,
    output logic               dec_halt,
    output pipe_pkg::word_t    dec_npc
);

    // instruction fields
    pipe_pkg::opcode_t  opcode;
    pipe_pkg::funct_t   funct;
    pipe_pkg::regbits_t rt_f;
    pipe_pkg::regbits_t rd_f;
    pipe_pkg::shamt_t   shamt_f;
    logic [15:0]        imm16;

    // decoded controls before the latch
    pipe_pkg::aluop_t   aluop;
    pipe_pkg::regbits_t rw;
    pipe_pkg::word_t    imm_ext;
    logic alusrc;
    logic memtoreg;
    logic dren;
    logic dwen;
    logic halt;
    logic zext;
    logic known;
    logic writes;

    assign opcode  = instr[31:26];
    assign rt_f    = instr[20:16];
    assign rd_f    = instr[15:11];
    assign shamt_f = instr[10:6];
    assign funct   = instr[5:0];
    assign imm16   = instr[15:0];

    // logical immediates zero-extend, the rest sign-extend
    assign imm_ext = zext ? {16'h0000, imm16} : {{16{imm16[15]}}, imm16};

    always_comb begin
        aluop    = pipe_pkg::ALU_ADD;
        alusrc   = 1'b1;
        rw       = rt_f;
        memtoreg = 1'b0;
        dren     = 1'b0;
        dwen     = 1'b0;
        halt     = 1'b0;
        zext     = 1'b0;
        known    = 1'b1;
        writes   = 1'b1;
        case (opcode)
            pipe_pkg::OP_RTYPE: begin
                // r-type writes rd, b side is rt
                alusrc = 1'b0;
                rw     = rd_f;
                case (funct)
                    pipe_pkg::FN_ADDU: aluop = pipe_pkg::ALU_ADD;
                    pipe_pkg::FN_SUBU: aluop = pipe_pkg::ALU_SUB;
                    pipe_pkg::FN_AND:  aluop = pipe_pkg::ALU_AND;
                    pipe_pkg::FN_OR:   aluop = pipe_pkg::ALU_OR;
                    pipe_pkg::FN_XOR:  aluop = pipe_pkg::ALU_XOR;
                    pipe_pkg::FN_NOR:  aluop = pipe_pkg::ALU_NOR;
                    pipe_pkg::FN_SLT:  aluop = pipe_pkg::ALU_SLT;
                    pipe_pkg::FN_SLTU: aluop = pipe_pkg::ALU_SLTU;
                    pipe_pkg::FN_SLL:  aluop = pipe_pkg::ALU_SLL;
                    pipe_pkg::FN_SRL:  aluop = pipe_pkg::ALU_SRL;
                    default:           known = 1'b0;
                endcase
            end
            pipe_pkg::OP_ADDIU: aluop = pipe_pkg::ALU_ADD;
            pipe_pkg::OP_SLTI:  aluop = pipe_pkg::ALU_SLT;
            pipe_pkg::OP_LUI:   aluop = pipe_pkg::ALU_LUI;
            pipe_pkg::OP_ANDI: begin
                aluop = pipe_pkg::ALU_AND;
                zext  = 1'b1;
            end
            pipe_pkg::OP_ORI: begin
                aluop = pipe_pkg::ALU_OR;
                zext  = 1'b1;
            end
            pipe_pkg::OP_XORI: begin
                aluop = pipe_pkg::ALU_XOR;
                zext  = 1'b1;
            end
            // address is rs + sign-extended offset
            pipe_pkg::OP_LW: begin
                memtoreg = 1'b1;
                dren     = 1'b1;
            end
            pipe_pkg::OP_SW: begin
                dwen   = 1'b1;
                writes = 1'b0;
            end
            pipe_pkg::OP_HALT: begin
                halt   = 1'b1;
                writes = 1'b0;
            end
            // unknown encodings pass as a no-op
            default: known = 1'b0;
        endcase
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST || flush) begin
            dec_valid    <= 1'b0;
            dec_aluop    <= '0;
            dec_alusrc   <= 1'b0;
            dec_port_a   <= '0;
            dec_port_b   <= '0;
            dec_imm_ext  <= '0;
            dec_shamt    <= '0;
            dec_rw       <= '0;
            dec_regwen   <= 1'b0;
            dec_memtoreg <= 1'b0;
            dec_dren     <= 1'b0;
            dec_dwen     <= 1'b0;
            dec_halt     <= 1'b0;
            dec_npc      <= '0;
        end else begin
            dec_valid <= instr_strobe;
            if (instr_strobe) begin
                dec_aluop    <= aluop;
                dec_alusrc   <= alusrc;
                dec_port_a   <= rs_data;
                dec_port_b   <= rt_data;
                dec_imm_ext  <= imm_ext;
                dec_shamt    <= shamt_f;
                dec_rw       <= rw;
                // no write to $0
                dec_regwen   <= known && writes && (rw != '0);
                dec_memtoreg <= memtoreg;
                dec_dren     <= dren;
                dec_dwen     <= dwen;
                dec_halt     <= halt;
                dec_npc      <= npc;
            end
        end
    end

    // a memory op is either a load or a store
    a_dec_rw_excl: assert property (@(posedge CLK) disable iff (!nRST)
        !(dec_dren && dec_dwen));

endmodule

`default_nettype wire

//--- source/execute_stage.sv
// execute_stage: selects ALU operands, runs the ALU, latches result and carried controls
`timescale 1ns/100ps
`default_nettype none

module execute_stage (
    input  logic               CLK,
    input  logic               nRST,
    input  logic               flush,
    input  logic               dec_valid,
    input  pipe_pkg::aluop_t   dec_aluop,
    input  logic               dec_alusrc,
    input  pipe_pkg::word_t    dec_port_a,
    input  pipe_pkg::word_t    dec_port_b,
    input  pipe_pkg::word_t    dec_imm_ext,
    input  pipe_pkg::shamt_t   dec_shamt,
    input  pipe_pkg::regbits_t dec_rw,
    input  logic               dec_regwen,
    input  logic               dec_memtoreg,
    input  logic               dec_dren,
    input  logic               dec_dwen,
    input  logic               dec_halt,
    input  pipe_pkg::word_t    dec_npc,
    output logic               ex_valid,
    output pipe_pkg::word_t    ex_port_o,
    output pipe_pkg::word_t    ex_port_b,
    output pipe_pkg::regbits_t ex_rw,
    output logic               ex_regwen,
    output logic               ex_memtoreg,
    output logic               ex_dren,
    output logic               ex_dwen,
    output logic               ex_halt,
    output pipe_pkg::word_t    ex_npc
);

    pipe_pkg::word_t alu_b;
    pipe_pkg::word_t alu_o;

    // immediate or rt on the b side
    assign alu_b = dec_alusrc ? dec_imm_ext : dec_port_b;

    // zero flag is for branches, not used here
    alu i_alu (
        .aluop  (dec_aluop),
        .port_a (dec_port_a),
        .port_b (alu_b),
        .shamt  (dec_shamt),
        .port_o (alu_o),
        .zero   ()
    );

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST || flush) begin
            ex_valid    <= 1'b0;
            ex_port_o   <= '0;
            ex_port_b   <= '0;
            ex_rw       <= '0;
            ex_regwen   <= 1'b0;
            ex_memtoreg <= 1'b0;
            ex_dren     <= 1'b0;
            ex_dwen     <= 1'b0;
            ex_halt     <= 1'b0;
            ex_npc      <= '0;
        end else begin
            ex_valid <= dec_valid;
            if (dec_valid) begin
                ex_port_o   <= alu_o;
                // rt carried on as store data
                ex_port_b   <= dec_port_b;
                ex_rw       <= dec_rw;
                ex_regwen   <= dec_regwen;
                ex_memtoreg <= dec_memtoreg;
                ex_dren     <= dec_dren;
                ex_dwen     <= dec_dwen;
                ex_halt     <= dec_halt;
                ex_npc      <= dec_npc;
            end
        end
    end

    // decode must never enable a write to $0
    a_ex_rw_nonzero: assert property (@(posedge CLK) disable iff (!nRST)
        ex_regwen |-> (ex_rw != '0));

endmodule

`default_nettype wire

//--- source/memory_stage.sv
// memory_stage: local data memory for loads and stores, registered writeback and halt flag
`timescale 1ns/100ps
`default_nettype none

module memory_stage (
    input  logic               CLK,
    input  logic               nRST,
    input  logic               ex_valid,
    input  pipe_pkg::word_t    ex_port_o,
    input  pipe_pkg::word_t    ex_port_b,
    input  pipe_pkg::regbits_t ex_rw,
    input  logic               ex_regwen,
    input  logic               ex_memtoreg,
    input  logic               ex_dren,
    input  logic               ex_dwen,
    input  logic               ex_halt,
    input  pipe_pkg::word_t    ex_npc,
    output logic               wb_valid,
    output logic               wb_wen,
    output pipe_pkg::regbits_t wb_reg,
    output pipe_pkg::word_t    wb_data,
    output pipe_pkg::word_t    wb_npc,
    output logic               halted
);

    pipe_pkg::word_t dmem [pipe_pkg::DMEM_WORDS];

    logic [pipe_pkg::DMEM_ADDR_W-1:0] dmem_idx;
    pipe_pkg::word_t load_data;
    pipe_pkg::word_t result;

    // word index, byte offset and upper bits dropped
    assign dmem_idx = ex_port_o[pipe_pkg::DMEM_ADDR_W+1:2];

    // same-cycle read, no stall
    assign load_data = ex_dren ? dmem[dmem_idx] : '0;
    assign result    = ex_memtoreg ? load_data : ex_port_o;

    // store lands on the same edge the item retires
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            for (int i = 0; i < pipe_pkg::DMEM_WORDS; i++) begin
                dmem[i] <= '0;
            end
        end else if (ex_valid && ex_dwen) begin
            dmem[dmem_idx] <= ex_port_b;
        end
    end

    // retire strobe and halt state
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            wb_valid <= 1'b0;
            wb_wen   <= 1'b0;
            halted   <= 1'b0;
        end else begin
            wb_valid <= ex_valid;
            wb_wen   <= ex_valid && ex_regwen;
            // sticky once halt retires
            if (ex_valid && ex_halt) begin
                halted <= 1'b1;
            end
        end
    end

    // writeback payload
    always_ff @(posedge CLK) begin
        if (ex_valid) begin
            wb_reg  <= ex_rw;
            wb_data <= result;
            wb_npc  <= ex_npc;
        end
    end

    // register write only with a retirement
    a_wb_wen_valid: assert property (@(posedge CLK) disable iff (!nRST)
        wb_wen |-> wb_valid);

endmodule

`default_nettype wire

//--- source/ex_pipe_top.sv
// ex_pipe_top: decode, execute and memory stages in a row between the external ports
`timescale 1ns/100ps
`default_nettype none

module ex_pipe_top (
    input  logic               CLK,
    input  logic               nRST,
    input  logic               instr_strobe,
    input  logic               flush,
    input  pipe_pkg::word_t    instr,
    input  pipe_pkg::word_t    rs_data,
    input  pipe_pkg::word_t    rt_data,
    input  pipe_pkg::word_t    npc,
    output logic               wb_valid,
    output logic               wb_wen,
    output pipe_pkg::regbits_t wb_reg,
    output pipe_pkg::word_t    wb_data,
    output pipe_pkg::word_t    wb_npc,
    output logic               halted
);

    // decode to execute
    logic               dec_valid;
    pipe_pkg::aluop_t   dec_aluop;
    logic               dec_alusrc;
    pipe_pkg::word_t    dec_port_a;
    pipe_pkg::word_t    dec_port_b;
    pipe_pkg::word_t    dec_imm_ext;
    pipe_pkg::shamt_t   dec_shamt;
    pipe_pkg::regbits_t dec_rw;
    logic               dec_regwen;
    logic               dec_memtoreg;
    logic               dec_dren;
    logic               dec_dwen;
    logic               dec_halt;
    pipe_pkg::word_t    dec_npc;

    // execute to memory
    logic               ex_valid;
    pipe_pkg::word_t    ex_port_o;
    pipe_pkg::word_t    ex_port_b;
    pipe_pkg::regbits_t ex_rw;
    logic               ex_regwen;
    logic               ex_memtoreg;
    logic               ex_dren;
    logic               ex_dwen;
    logic               ex_halt;
    pipe_pkg::word_t    ex_npc;

    decode_stage i_decode_stage (.*);

    execute_stage i_execute_stage (.*);

    // memory stage ignores flush, its item retires
    memory_stage i_memory_stage (.*);

endmodule

`default_nettype wire

//--- bench/tb_ex_pipe.sv
// random instruction stream through the pipeline slice checked against an in-order model
`timescale 1ns/100ps
`default_nettype none

module tb_ex_pipe;

    localparam int RESET_CYCLES = 10;
    localparam int STIM_CYCLES  = 400;
    // twice the stimulus length including halt and idle cycle plus margin
    localparam int CYCLE_LIMIT  = 2 * (RESET_CYCLES + STIM_CYCLES + 2) + 100;

    // one expected retirement with acc as the edge where decode latched it
    typedef struct packed {
        int              acc;
        logic            wen;
        logic [4:0]      rd;
        pipe_pkg::word_t data;
        pipe_pkg::word_t npc;
        logic            load;
        logic            store;
        pipe_pkg::word_t addr;
        pipe_pkg::word_t sdata;
        logic            halt;
    } exp_t;

    logic               CLK = 1'b0;
    logic               nRST;
    logic               instr_strobe;
    logic               flush;
    pipe_pkg::word_t    instr;
    pipe_pkg::word_t    rs_data;
    pipe_pkg::word_t    rt_data;
    pipe_pkg::word_t    npc;
    logic               wb_valid;
    logic               wb_wen;
    pipe_pkg::regbits_t wb_reg;
    pipe_pkg::word_t    wb_data;
    pipe_pkg::word_t    wb_npc;
    logic               halted;

    // model state owned by the checker
    exp_t            exp_q[$];
    pipe_pkg::word_t model_mem [pipe_pkg::DMEM_WORDS];
    logic            model_halted = 1'b0;
    int              edge_no  = 0;
    int              errors   = 0;
    int              retired  = 0;
    int              squashed = 0;
    int              cycles   = 0;

    // stimulus state
    integer          seed;
    pipe_pkg::word_t pc;
    logic            prev_sw;
    pipe_pkg::word_t sw_rs;
    logic [15:0]     sw_imm;

    ex_pipe_top i_ex_pipe_top (.*);

    always #5 CLK = ~CLK;

    function automatic pipe_pkg::funct_t pick_funct(logic [3:0] k);
        case (k)
            4'd0, 4'd10: return pipe_pkg::FN_ADDU;
            4'd1, 4'd11: return pipe_pkg::FN_SUBU;
            4'd2:        return pipe_pkg::FN_AND;
            4'd3:        return pipe_pkg::FN_OR;
            4'd4:        return pipe_pkg::FN_XOR;
            4'd5:        return pipe_pkg::FN_NOR;
            4'd6, 4'd12: return pipe_pkg::FN_SLT;
            4'd7, 4'd13: return pipe_pkg::FN_SLTU;
            4'd8:        return pipe_pkg::FN_SLL;
            4'd9:        return pipe_pkg::FN_SRL;
            // unsupported functs retire as no-ops
            4'd14:       return 6'h3b;
            default:     return 6'h1a;
        endcase
    endfunction

    function automatic pipe_pkg::opcode_t pick_iop(logic [3:0] k);
        case (k)
            4'd0, 4'd1, 4'd12: return pipe_pkg::OP_ADDIU;
            4'd2, 4'd3:        return pipe_pkg::OP_ANDI;
            4'd4, 4'd5:        return pipe_pkg::OP_ORI;
            4'd6, 4'd7:        return pipe_pkg::OP_XORI;
            4'd8, 4'd9, 4'd13: return pipe_pkg::OP_SLTI;
            4'd10, 4'd11:      return pipe_pkg::OP_LUI;
            // branch and an unused opcode both outside the slice
            4'd14:             return 6'h04;
            default:           return 6'h3c;
        endcase
    endfunction

    // expected writeback for one accepted instruction
    function automatic exp_t predict(pipe_pkg::word_t iw, pipe_pkg::word_t a,
                                     pipe_pkg::word_t b, pipe_pkg::word_t pc_next, int acc);
        exp_t            e;
        pipe_pkg::word_t simm;
        pipe_pkg::word_t zimm;
        logic            writes;
        simm   = {{16{iw[15]}}, iw[15:0]};
        zimm   = {16'h0000, iw[15:0]};
        e      = '0;
        e.acc  = acc;
        e.npc  = pc_next;
        e.rd   = iw[20:16];
        writes = 1'b1;
        case (iw[31:26])
            pipe_pkg::OP_RTYPE: begin
                e.rd = iw[15:11];
                case (iw[5:0])
                    pipe_pkg::FN_ADDU: e.data = a + b;
                    pipe_pkg::FN_SUBU: e.data = a - b;
                    pipe_pkg::FN_AND:  e.data = a & b;
                    pipe_pkg::FN_OR:   e.data = a | b;
                    pipe_pkg::FN_XOR:  e.data = a ^ b;
                    pipe_pkg::FN_NOR:  e.data = ~(a | b);
                    pipe_pkg::FN_SLT:  e.data = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    pipe_pkg::FN_SLTU: e.data = (a < b) ? 32'd1 : 32'd0;
                    pipe_pkg::FN_SLL:  e.data = b << iw[10:6];
                    pipe_pkg::FN_SRL:  e.data = b >> iw[10:6];
                    default:           writes = 1'b0;
                endcase
            end
            pipe_pkg::OP_ADDIU: e.data = a + simm;
            pipe_pkg::OP_SLTI:  e.data = ($signed(a) < $signed(simm)) ? 32'd1 : 32'd0;
            pipe_pkg::OP_ANDI:  e.data = a & zimm;
            pipe_pkg::OP_ORI:   e.data = a | zimm;
            pipe_pkg::OP_XORI:  e.data = a ^ zimm;
            pipe_pkg::OP_LUI:   e.data = {iw[15:0], 16'h0000};
            pipe_pkg::OP_LW: begin
                e.load = 1'b1;
                e.addr = a + simm;
            end
            pipe_pkg::OP_SW: begin
                e.store = 1'b1;
                e.addr  = a + simm;
                e.sdata = b;
                writes  = 1'b0;
            end
            pipe_pkg::OP_HALT: begin
                e.halt = 1'b1;
                writes = 1'b0;
            end
            default: writes = 1'b0;
        endcase
        // $0 is never written
        e.wen = writes && (e.rd != 5'd0);
        return e;
    endfunction

    task automatic flag_mismatch(string name, pipe_pkg::word_t expv, pipe_pkg::word_t actv);
        $display("Mismatch at %0d ns: %s expected %h, got %h", $time, name, expv, actv);
        errors++;
    endtask

    task automatic note_failure(string what);
        $display("Error at %0d ns: %s", $time, what);
        errors++;
    endtask

    // one cycle of random stimulus seen by the DUT at the next edge
    task automatic drive_random();
        pipe_pkg::word_t r;
        pipe_pkg::word_t iw;
        pipe_pkg::word_t a;
        pipe_pkg::word_t b;
        r  = $random(seed);
        iw = $random(seed);
        a  = $random(seed);
        b  = $random(seed);
        flush        <= (r[3:0] == 4'd0);
        instr_strobe <= (r[5:4] != 2'd0);
        if (r[5:4] != 2'd0) begin
            if (prev_sw && r[6]) begin
                // read back the word just stored
                iw      = {pipe_pkg::OP_LW, iw[25:16], sw_imm};
                a       = sw_rs;
                prev_sw = 1'b0;
            end else if (r[10:8] <= 3'd2) begin
                iw = {pipe_pkg::OP_RTYPE, iw[25:6], pick_funct(r[15:12])};
                // some writes aimed at $0
                if (r[18:16] == 3'd0) begin
                    iw[15:11] = 5'd0;
                end
                prev_sw = 1'b0;
            end else if (r[10:8] <= 3'd4) begin
                iw      = {pick_iop(r[15:12]), iw[25:0]};
                prev_sw = 1'b0;
            end else begin
                // narrow window of about 16 words with offset -16..15
                a       = {a[31:8], 3'b010, a[4:0]};
                iw      = {r[11] ? pipe_pkg::OP_SW : pipe_pkg::OP_LW, iw[25:16],
                           {11{iw[4]}}, iw[4:0]};
                prev_sw = r[11];
                sw_rs   = a;
                sw_imm  = iw[15:0];
            end
            pc = pc + 32'd4;
        end
        instr   <= iw;
        rs_data <= a;
        rt_data <= b;
        npc     <= pc;
    endtask

    // compare outputs then advance the model with this edge's inputs
    always @(posedge CLK) begin
        exp_t e;
        logic due;
        logic exp_wen;
        e = '0;
        edge_no++;
        if (!nRST) begin
            // first edge may come before the async reset has acted
            if (edge_no > 1 &&
                (wb_valid !== 1'b0 || wb_wen !== 1'b0 || halted !== 1'b0)) begin
                note_failure("wb_valid, wb_wen or halted high during reset");
            end
            // memory clears with reset
            for (int i = 0; i < pipe_pkg::DMEM_WORDS; i++) begin
                model_mem[i] = '0;
            end
            model_halted = 1'b0;
            exp_q.delete();
        end else begin
            due = (exp_q.size() > 0) && (exp_q[0].acc == edge_no - 3);
            if (due) begin
                e = exp_q.pop_front();
                // memory effects in retirement order
                if (e.load) begin
                    e.data = model_mem[e.addr[7:2]];
                end
                if (e.store) begin
                    model_mem[e.addr[7:2]] = e.sdata;
                end
                if (e.halt) begin
                    model_halted = 1'b1;
                end
                retired++;
            end
            exp_wen = due && e.wen;
            if (due && wb_valid !== 1'b1) begin
                note_failure("an instruction did not retire three edges after its strobe");
            end
            if (!due && wb_valid !== 1'b0) begin
                note_failure("wb_valid high with no instruction due");
            end
            if (wb_wen !== exp_wen) begin
                flag_mismatch("wb_wen", {31'd0, exp_wen}, {31'd0, wb_wen});
            end
            if (due && wb_valid === 1'b1) begin
                if (wb_npc !== e.npc) begin
                    flag_mismatch("wb_npc", e.npc, wb_npc);
                end
                if (e.wen && wb_reg !== e.rd) begin
                    flag_mismatch("wb_reg", {27'd0, e.rd}, {27'd0, wb_reg});
                end
                if (e.wen && wb_data !== e.data) begin
                    flag_mismatch("wb_data", e.data, wb_data);
                end
            end
            if (halted !== model_halted) begin
                flag_mismatch("halted", {31'd0, model_halted}, {31'd0, halted});
            end
            // flush kills the item in decode and the strobe of this edge
            if (flush) begin
                while (exp_q.size() > 0 && exp_q[exp_q.size() - 1].acc == edge_no - 1) begin
                    void'(exp_q.pop_back());
                    squashed++;
                end
            end else if (instr_strobe) begin
                exp_q.push_back(predict(instr, rs_data, rt_data, npc, edge_no));
            end
        end
    end

    // run limit
    always @(posedge CLK) begin
        cycles++;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Timeout after %0d cycles, halt never retired or model not drained",
                     cycles);
            $display("summary: %0d retired, %0d squashed, %0d errors", retired, squashed,
                     errors);
            $display("Some tests failed");
            $finish;
        end
    end

    initial begin
        seed         = 32'he394fa57;
        nRST         = 1'b0;
        instr_strobe = 1'b0;
        flush        = 1'b0;
        instr        = '0;
        rs_data      = '0;
        rt_data      = '0;
        npc          = '0;
        pc           = 32'h0040_0000;
        prev_sw      = 1'b0;
        sw_rs        = '0;
        sw_imm       = '0;
        repeat (RESET_CYCLES) @(posedge CLK);
        nRST <= 1'b1;
        for (int n = 0; n < STIM_CYCLES; n++) begin
            @(posedge CLK);
            drive_random();
        end
        // halt ends the stream with no flush next to it
        @(posedge CLK);
        instr_strobe <= 1'b1;
        flush        <= 1'b0;
        instr        <= {pipe_pkg::OP_HALT, 26'h0};
        npc          <= pc + 32'd4;
        @(posedge CLK);
        instr_strobe <= 1'b0;
        // wait for halt to retire and the model queue to empty
        @(negedge CLK);
        while (!(halted === 1'b1 && exp_q.size() == 0)) begin
            @(negedge CLK);
        end
        // halted must hold
        repeat (4) @(negedge CLK);
        $display("summary: %0d retired, %0d squashed, %0d errors", retired, squashed, errors);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- sim.f
source/pipe_pkg.sv
source/alu.sv
source/decode_stage.sv
source/execute_stage.sv
source/memory_stage.sv
source/ex_pipe_top.sv
bench/tb_ex_pipe.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_ex_pipe
FILELIST  = sim.f
OBJDIR    = obj_dir
LOG       = sim.log

.PHONY: simulate clean

simulate:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)
	./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "Some tests failed" $(LOG); then \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi
	@grep -q "All tests passed" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)
